//--- dv/slc3Chk.sv
`timescale 1ns/1ps
//--------------------------------------------------------------------------
// Wishbone and reset assertions, bound into every slc3Core
// The reset check needs the clock running while arstN rises
//--------------------------------------------------------------------------

module slc3Chk import slc3Pkg::*;
(
	input logic Clk,
	input logic arstN,
	input wbReqT wbReq,
	input wbRspT wbRsp,
	input seqStateE state
);

	// Cycle stays open until the slave acks
	cycHeld: assert property (@(posedge Clk) disable iff (!arstN)
		wbReq.stb && !wbRsp.ack |=> wbReq.cyc && wbReq.stb)
		else $error("cycle dropped before ack");

	// Cycle closes in the cycle after ack
	cycEnds: assert property (@(posedge Clk) disable iff (!arstN)
		wbReq.stb && wbRsp.ack |=> !wbReq.cyc)
		else $error("cycle still open after ack");

	// Request held until the slave acks
	reqStable: assert property (@(posedge Clk) disable iff (!arstN)
		wbReq.stb && !wbRsp.ack |=>
			$stable(wbReq.adr) && $stable(wbReq.we) && $stable(wbReq.dat))
		else $error("request changed during a wait state");

	// First cycle out of reset is idle and halted
	idleAfterReset: assert property (@(posedge Clk)
		$rose(arstN) |-> !wbReq.cyc && state == halted)
		else $error("bus cycle or wrong state right after reset");

endmodule

bind slc3Core slc3Chk chk
(
	.Clk(Clk),
	.arstN(arstN),
	.wbReq(wbReq),
	.wbRsp(wbRsp),
	.state(state)
);

//--- dv/slc3Tb.sv
`timescale 1ns/1ps
//--------------------------------------------------------------------------
// Random program testbench for slc3Core with a 256-word Wishbone memory
// Program sits low, data region at 0xC0, table entries at 0xD0 and up
// Checks reads and writes in ack order against an ISA model
//--------------------------------------------------------------------------
`include "slc3_params.svh"

module slc3Tb import slc3Pkg::*;
();

	logic Clk;
	logic arstN;
	logic run;
	logic cont;
	wbReqT wbReq;
	wbRspT wbRsp;
	logic [11:0] led;

	logic [`SLC3_WORD-1:0] mem [256]; // Memory seen by the DUT
	logic [`SLC3_WORD-1:0] image [256]; // Copy for the model
	logic [15:0] lfsr;
	logic [15:0] readQ [$]; // Expected fetch and load addresses
	logic [31:0] storeQ [$]; // {addr, data}
	logic [11:0] expLed;
	int genPc;
	int readIdx;
	int storeIdx;
	int waitCnt;
	int mismatches;
	int otherErrors;
	int cycleCnt;
	int cycleLimit;
	int savedIdx;

	slc3Core uut
	(
		.Clk(Clk),
		.arstN(arstN),
		.run(run),
		.cont(cont),
		.wbReq(wbReq),
		.wbRsp(wbRsp),
		.led(led)
	);

	initial
	begin
		Clk = 1'b0;
		forever #50 Clk = ~Clk; // 100 ns period
	end

	//--------------------------------------------------------------------------
	// Random source and encoders
	//--------------------------------------------------------------------------
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// One LFSR step per bit
	function automatic logic [15:0] randBits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			v = {v[14:0], lfsr[0]};
			lfsr = lfsrNext(lfsr);
		end
		return v;
	endfunction

	function automatic logic [15:0] sext(input logic [15:0] v, input int bits);
		logic signed [15:0] t;
		t = v << (16 - bits);
		return t >>> (16 - bits);
	endfunction

	function automatic logic [15:0] encFmt(input logic [3:0] op, input logic [2:0] a,
		input logic [2:0] b, input logic [5:0] lo);
		return {op, a, b, lo};
	endfunction

	// Any register but R6, which holds the data base
	function automatic logic [2:0] pickReg();
		logic [2:0] r;
		r = 3'(randBits(3));
		return (r == 3'd6) ? 3'd7 : r;
	endfunction

	task automatic put(input logic [15:0] w);
		image[genPc] = w;
		genPc++;
	endtask

	//--------------------------------------------------------------------------
	// Program generator
	//--------------------------------------------------------------------------
	task automatic buildProgram();
		logic [2:0] kind;
		logic [2:0] r;
		logic [1:0] off;
		int tableIdx;
		int reach;
		for (int a = 0; a < 256; a++)
			image[a] = {a[7:0] ^ 8'h3C, ~a[7:0]}; // Fill tied to the full address
		for (int d = 0; d < 16; d++)
			image[8'hC0 + d] = randBits(16);
		genPc = 0;
		reach = 0; // Farthest branch or jump target so far
		put(encFmt(4'b0110, 3'd6, 3'd0, 6'd2)); // R6 <- M[2]
		put({4'b0000, 3'b111, 9'd1}); // Skip the base word
		put(16'h00C0);
		for (int k = 0; k < 8; k++)
			if (k != 6)
				put(encFmt(4'b0110, 3'(k), 3'd6, 6'(k)));
		tableIdx = 16;
		for (int n = 0; n < 60; n++)
		begin
			kind = 3'(randBits(3));
			if (n >= 56 && kind >= 3'd5)
				kind = 3'd3; // No jumps near the PAUSE
			if (kind == 3'd7 && (tableIdx >= 32 || genPc + 1 <= reach))
				kind = 3'd3; // A landing on the JMP would skip its table load
			case (kind)
				3'd0, 3'd1:
				begin
					if (randBits(1) == 16'd1)
						put(encFmt(kind == 3'd0 ? 4'b0001 : 4'b0101, pickReg(),
							3'(randBits(3)), {1'b1, 5'(randBits(5))}));
					else
						put(encFmt(kind == 3'd0 ? 4'b0001 : 4'b0101, pickReg(),
							3'(randBits(3)), {3'b000, 3'(randBits(3))}));
				end
				3'd2: put(encFmt(4'b1001, pickReg(), 3'(randBits(3)), 6'h3F));
				3'd3: put(encFmt(4'b0111, 3'(randBits(3)), 3'd6, {2'b00, 4'(randBits(4))}));
				3'd4: put(encFmt(4'b0110, pickReg(), 3'd6, {2'b00, 4'(randBits(4))}));
				3'd5:
				begin
					r = 3'(randBits(3)); // nzp mask
					off = 2'(randBits(2));
					if (genPc + 1 + off > reach)
						reach = genPc + 1 + off;
					put({4'b0000, r, 7'd0, off}); // BR forward 0 to 3
				end
				3'd6:
				begin
					off = 2'(randBits(2));
					if (genPc + 1 + off > reach)
						reach = genPc + 1 + off;
					put({4'b0100, 1'b1, 9'd0, off}); // JSR forward 0 to 3
				end
				default:
				begin
					r = pickReg();
					off = 2'(randBits(2));
					put(encFmt(4'b0110, r, 3'd6, 6'(tableIdx)));
					image[8'hC0 + tableIdx] = 16'(genPc + 1 + off); // JMP target
					if (genPc + 1 + off > reach)
						reach = genPc + 1 + off;
					put(encFmt(4'b1100, 3'd0, r, 6'd0));
					tableIdx++;
				end
			endcase
		end
		put({4'b1101, 12'(randBits(12))}); // PAUSE
		mem = image;
	endtask

	//--------------------------------------------------------------------------
	// ISA model, timing free
	//--------------------------------------------------------------------------
	task automatic runModel();
		logic [15:0] r [8];
		logic [15:0] pc;
		logic [15:0] ir;
		logic [15:0] a;
		logic [15:0] opnd;
		logic [15:0] res;
		logic [2:0] cc;
		logic done;
		r = '{default: '0};
		pc = `SLC3_START_PC;
		cc = 3'b010;
		done = 1'b0;
		for (int step = 0; step < 1000 && !done; step++)
		begin
			readQ.push_back(pc);
			ir = image[pc[7:0]];
			pc = pc + 16'd1;
			res = '0;
			case (ir[15:12])
				4'b0001, 4'b0101, 4'b1001:
				begin
					opnd = ir[5] ? sext({11'd0, ir[4:0]}, 5) : r[ir[2:0]];
					if (ir[15:12] == 4'b0001)
						res = r[ir[8:6]] + opnd;
					else if (ir[15:12] == 4'b0101)
						res = r[ir[8:6]] & opnd;
					else
						res = ~r[ir[8:6]];
					r[ir[11:9]] = res;
					cc = {res[15], res == 16'd0, !res[15] && res != 16'd0};
				end
				4'b0000:
					if ((ir[11:9] & cc) != 3'b000)
						pc = pc + sext({7'd0, ir[8:0]}, 9);
				4'b1100: pc = r[ir[8:6]];
				4'b0100:
					if (ir[11])
					begin
						r[7] = pc; // Link first, then jump
						pc = pc + sext({5'd0, ir[10:0]}, 11);
					end
				4'b0110:
				begin
					a = r[ir[8:6]] + sext({10'd0, ir[5:0]}, 6);
					readQ.push_back(a);
					res = image[a[7:0]];
					r[ir[11:9]] = res;
					cc = {res[15], res == 16'd0, !res[15] && res != 16'd0};
				end
				4'b0111:
				begin
					a = r[ir[8:6]] + sext({10'd0, ir[5:0]}, 6);
					storeQ.push_back({a, r[ir[11:9]]});
					image[a[7:0]] = r[ir[11:9]];
				end
				4'b1101:
				begin
					expLed = ir[11:0];
					readQ.push_back(pc); // Fetch after the release
					done = 1'b1;
				end
				default: ;
			endcase
		end
		if (!done)
		begin
			$display("Model never reached the final PAUSE");
			otherErrors++;
		end
	endtask

	//--------------------------------------------------------------------------
	// Wishbone slave with random wait states
	//--------------------------------------------------------------------------
	always @(posedge Clk)
	begin
		if (wbReq.cyc && wbReq.stb && wbRsp.ack)
		begin
			wbRsp.ack <= 1'b0; // Cycle ends on this edge
			waitCnt <= int'(randBits(2));
			if (wbReq.we)
			begin
				mem[wbReq.adr[7:0]] <= wbReq.dat;
				if (storeIdx >= storeQ.size())
				begin
					$display("Unexpected write to %h at %0t", wbReq.adr, $time);
					otherErrors++;
				end
				else if ({wbReq.adr, wbReq.dat} != storeQ[storeIdx])
				begin
					$display("MISMATCH at %0t: write %h <- %h, expected %h <- %h", $time,
						wbReq.adr, wbReq.dat, storeQ[storeIdx][31:16], storeQ[storeIdx][15:0]);
					mismatches++;
				end
				storeIdx++;
			end
			else
			begin
				if (readIdx >= readQ.size())
				begin
					$display("Unexpected read from %h at %0t", wbReq.adr, $time);
					otherErrors++;
				end
				else if (wbReq.adr != readQ[readIdx])
				begin
					$display("MISMATCH at %0t: read address %h, expected %h", $time,
						wbReq.adr, readQ[readIdx]);
					mismatches++;
				end
				readIdx++;
			end
		end
		else if (wbReq.cyc && wbReq.stb)
		begin
			if (waitCnt == 0)
			begin
				wbRsp.ack <= 1'b1;
				wbRsp.dat <= mem[wbReq.adr[7:0]];
			end
			else
				waitCnt <= waitCnt - 1;
		end
	end

	// Run limit
	always @(posedge Clk)
	begin
		cycleCnt <= cycleCnt + 1;
		if (cycleCnt > cycleLimit)
		begin
			$display("Timeout: run did not finish within %0d cycles", cycleLimit);
			$display("Testbench failed");
			$finish;
		end
	end

	//--------------------------------------------------------------------------
	// Main sequence
	//--------------------------------------------------------------------------
	initial
	begin
		arstN = 1'b0;
		run = 1'b0;
		cont = 1'b0;
		wbRsp = '0;
		lfsr = 16'd53;
		readIdx = 0;
		storeIdx = 0;
		waitCnt = 0;
		mismatches = 0;
		otherErrors = 0;
		cycleCnt = 0;
		cycleLimit = 100000;
		buildProgram();
		runModel();
		cycleLimit = 40 * genPc + 100; // 40 cycles per program word
		repeat (8) @(posedge Clk);
		arstN <= 1'b1;
		repeat (5)
		begin
			@(negedge Clk);
			if (wbReq.cyc || led != 12'd0)
			begin
				$display("Core left idle before run at %0t", $time);
				otherErrors++;
			end
		end
		@(posedge Clk);
		run <= 1'b1;
		@(posedge Clk);
		run <= 1'b0;
		// First read address is covered by readQ[0]
		while (readIdx < readQ.size() - 1)
			@(posedge Clk);
		savedIdx = readIdx;
		repeat (6) @(posedge Clk); // Past loadIr, decode and pauseHold
		@(negedge Clk);
		if (led != expLed)
		begin
			$display("MISMATCH at %0t: led %h, expected %h", $time, led, expLed);
			mismatches++;
		end
		@(posedge Clk);
		cont <= 1'b1;
		repeat (4) @(posedge Clk);
		@(negedge Clk);
		if (readIdx != savedIdx || wbReq.cyc)
		begin
			$display("Fetch started before cont was released at %0t", $time);
			otherErrors++;
		end
		@(posedge Clk);
		cont <= 1'b0;
		while (readIdx < readQ.size())
			@(posedge Clk);
		if (storeIdx != storeQ.size())
		begin
			$display("Only %0d of %0d expected writes seen", storeIdx, storeQ.size());
			otherErrors++;
		end
		$display("Errors: %0d mismatches, %0d other failures", mismatches, otherErrors);
		if (mismatches == 0 && otherErrors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

//--- flist.f
+incdir+logic
logic/slc3Pkg.sv
logic/controlSequencer.sv
logic/registerFile.sv
logic/slc3Datapath.sv
logic/slc3Core.sv
dv/slc3Chk.sv
dv/slc3Tb.sv

//--- logic/controlSequencer.sv
`timescale 1ns/1ps
//--------------------------------------------------------------------------
// Moore sequencer for the LC-3 subset, one instruction in flight
// Memory states hold until Wishbone ack, any number of wait cycles
// JSRR and unknown opcodes go straight back to fetch
//--------------------------------------------------------------------------

module controlSequencer import slc3Pkg::*;
(
	input logic Clk,
	input logic arstN,
	input logic run,
	input logic cont,
	input logic [3:0] opcode,
	input logic jsrFlag,
	input logic ben,
	input logic ack,
	output ctrlT ctrl,
	output seqStateE state
);

	seqStateE nextState;

	always_ff @(posedge Clk or negedge arstN)
	begin
		if (!arstN)
			state <= halted;
		else
			state <= nextState;
	end

	//--------------------------------------------------------------------------
	// Next state
	//--------------------------------------------------------------------------
	always_comb
	begin
		nextState = state; // Hold by default
		unique case (state)
			halted:
				if (run)
					nextState = fetchAddr;
			fetchAddr:
				nextState = fetchWait;
			fetchWait:
				if (ack)
					nextState = loadIr; // Word now in MDR
			loadIr:
				nextState = decode;
			decode:
				case (opcode)
					4'b0001: nextState = execAdd;
					4'b0101: nextState = execAnd;
					4'b1001: nextState = execNot;
					4'b0000: nextState = brTest;
					4'b1100: nextState = jmp;
					4'b0100: nextState = jsrFlag ? jsrLink : fetchAddr; // JSRR unsupported
					4'b0110: nextState = ldrAddr;
					4'b0111: nextState = strAddr;
					4'b1101: nextState = pauseHold;
					default: nextState = fetchAddr;
				endcase
			execAdd, execAnd, execNot, jmp, brTake, jsrJump, ldrWrite:
				nextState = fetchAddr;
			brTest:
				nextState = ben ? brTake : fetchAddr; // BEN from decode
			jsrLink:
				nextState = jsrJump;
			ldrAddr:
				nextState = ldrWait;
			ldrWait:
				if (ack)
					nextState = ldrWrite;
			strAddr:
				nextState = strData;
			strData:
				nextState = strWait;
			strWait:
				if (ack)
					nextState = fetchAddr;
			pauseHold:
				if (cont)
					nextState = pauseRelease;
			pauseRelease:
				if (!cont)
					nextState = fetchAddr; // Resume on falling cont
			default:
				nextState = halted;
		endcase
	end

	//--------------------------------------------------------------------------
	// Control word per state
	//--------------------------------------------------------------------------
	always_comb
	begin
		ctrl = '0; // Everything idle unless set below
		unique case (state)
			fetchAddr:
			begin
				ctrl.gatePc = 1'b1; // MAR <- PC
				ctrl.ldMar = 1'b1;
				ctrl.pcmux = 2'b00; // PC <- PC + 1
				ctrl.ldPc = 1'b1;
			end
			fetchWait, ldrWait:
			begin
				ctrl.memReq = 1'b1; // Read M[MAR]
				ctrl.ldMdr = 1'b1; // Taken on ack
			end
			loadIr:
			begin
				ctrl.gateMdr = 1'b1;
				ctrl.ldIr = 1'b1;
			end
			decode:
				ctrl.ldBen = 1'b1; // Mask nzp with previous CC
			execAdd, execAnd, execNot:
			begin
				ctrl.drmux = 1'b1; // DR from IR[11:9]
				ctrl.sr1mux = 1'b1; // SR1 from IR[8:6]
				ctrl.sr2mux = 1'b1; // IR[5] then picks imm5
				ctrl.gateAlu = 1'b1;
				ctrl.ldReg = 1'b1;
				ctrl.ldCc = 1'b1;
				if (state == execAdd)
					ctrl.aluk = 2'b00;
				else if (state == execAnd)
					ctrl.aluk = 2'b01;
				else
					ctrl.aluk = 2'b10;
			end
			brTake:
			begin
				ctrl.addr1mux = 1'b1; // PC + SEXT off9
				ctrl.addr2mux = 2'b01;
				ctrl.pcmux = 2'b10;
				ctrl.ldPc = 1'b1;
			end
			jmp:
			begin
				ctrl.sr1mux = 1'b1; // BaseR + 0
				ctrl.addr1mux = 1'b0;
				ctrl.addr2mux = 2'b11;
				ctrl.pcmux = 2'b10;
				ctrl.ldPc = 1'b1;
			end
			jsrLink:
			begin
				ctrl.drmux = 1'b0; // R7 <- incremented PC
				ctrl.gatePc = 1'b1;
				ctrl.ldReg = 1'b1;
			end
			jsrJump:
			begin
				ctrl.addr1mux = 1'b1; // PC + SEXT off11
				ctrl.addr2mux = 2'b00;
				ctrl.pcmux = 2'b10;
				ctrl.ldPc = 1'b1;
			end
			ldrAddr, strAddr:
			begin
				ctrl.sr1mux = 1'b1; // MAR <- BaseR + SEXT off6
				ctrl.addr1mux = 1'b0;
				ctrl.addr2mux = 2'b10;
				ctrl.gateMarmux = 1'b1;
				ctrl.ldMar = 1'b1;
			end
			ldrWrite:
			begin
				ctrl.drmux = 1'b1;
				ctrl.gateMdr = 1'b1; // DR <- MDR
				ctrl.ldReg = 1'b1;
				ctrl.ldCc = 1'b1;
			end
			strData:
			begin
				ctrl.sr1mux = 1'b0; // SR from IR[11:9]
				ctrl.addr1mux = 1'b0; // Pass SR through the adder
				ctrl.addr2mux = 2'b11;
				ctrl.gateMarmux = 1'b1;
				ctrl.ldMdr = 1'b1;
			end
			strWait:
			begin
				ctrl.memReq = 1'b1; // M[MAR] <- MDR
				ctrl.memWe = 1'b1;
			end
			pauseHold:
				ctrl.ldLed = 1'b1; // Show IR[11:0]
			default: ;
		endcase
	end

endmodule

//--- logic/registerFile.sv
`timescale 1ns/1ps
//--------------------------------------------------------------------------
// General purpose registers, one write port and two read ports
// Reads are combinational, so a write shows on the next cycle
//--------------------------------------------------------------------------
`include "slc3_params.svh"

module registerFile
(
	input logic Clk,
	input logic arstN,
	input logic we,
	input logic [$clog2(`SLC3_NREG)-1:0] wAddr,
	input logic [$clog2(`SLC3_NREG)-1:0] rAddr1,
	input logic [$clog2(`SLC3_NREG)-1:0] rAddr2,
	input logic [`SLC3_WORD-1:0] wData,
	output logic [`SLC3_WORD-1:0] rData1,
	output logic [`SLC3_WORD-1:0] rData2
);

	logic [`SLC3_WORD-1:0] regs [`SLC3_NREG]; // R0 to R7

	always_ff @(posedge Clk or negedge arstN)
	begin
		if (!arstN)
			regs <= '{default: '0}; // All registers zero
		else if (we)
			regs[wAddr] <= wData;
	end

	assign rData1 = regs[rAddr1]; // SR1 or BaseR
	assign rData2 = regs[rAddr2]; // SR2

endmodule

//--- logic/slc3Core.sv
`timescale 1ns/1ps
//--------------------------------------------------------------------------
// SLC-3 core top, sequencer plus datapath
// Memory sits outside on the Wishbone master port
//--------------------------------------------------------------------------

module slc3Core import slc3Pkg::*;
(
	input logic Clk,
	input logic arstN,
	input logic run,
	input logic cont,
	output wbReqT wbReq,
	input wbRspT wbRsp,
	output logic [11:0] led
);

	ctrlT ctrl;
	seqStateE state; // Observed by the bound checker
	logic [3:0] opcode;
	logic jsrFlag;
	logic ben;

	controlSequencer seq
	(
		.Clk(Clk),
		.arstN(arstN),
		.run(run),
		.cont(cont),
		.opcode(opcode),
		.jsrFlag(jsrFlag),
		.ben(ben),
		.ack(wbRsp.ack), // Straight from the slave
		.ctrl(ctrl),
		.state(state)
	);

	slc3Datapath dp
	(
		.Clk(Clk),
		.arstN(arstN),
		.ctrl(ctrl),
		.wbReq(wbReq),
		.wbRsp(wbRsp),
		.opcode(opcode),
		.jsrFlag(jsrFlag),
		.ben(ben),
		.led(led)
	);

endmodule

//--- logic/slc3Datapath.sv
`timescale 1ns/1ps
//--------------------------------------------------------------------------
// 16-bit SLC-3 datapath with a single internal bus
// Wishbone request follows ctrl.memReq combinationally, MDR takes read
// data on the ack edge. Bus gates are expected to be one-hot
//--------------------------------------------------------------------------
`include "slc3_params.svh"

module slc3Datapath import slc3Pkg::*;
(
	input logic Clk,
	input logic arstN,
	input ctrlT ctrl,
	output wbReqT wbReq,
	input wbRspT wbRsp,
	output logic [3:0] opcode,
	output logic jsrFlag,
	output logic ben,
	output logic [11:0] led
);

	logic [`SLC3_WORD-1:0] pc;
	logic [`SLC3_WORD-1:0] mar;
	logic [`SLC3_WORD-1:0] mdr;
	instrU ir;
	logic [2:0] cc; // N, Z, P
	logic [`SLC3_WORD-1:0] bus;
	logic [`SLC3_WORD-1:0] srA;
	logic [`SLC3_WORD-1:0] srB;
	logic [`SLC3_WORD-1:0] opB;
	logic [`SLC3_WORD-1:0] aluOut;
	logic [`SLC3_WORD-1:0] addrBase;
	logic [`SLC3_WORD-1:0] addrOff;
	logic [`SLC3_WORD-1:0] addrSum;
	logic [$clog2(`SLC3_NREG)-1:0] sr1Addr;
	logic [$clog2(`SLC3_NREG)-1:0] drAddr;

	assign opcode = ir.op.opcode;
	assign jsrFlag = ir.ctl.f.jsr.jsrFlag;

	//--------------------------------------------------------------------------
	// Register file and operand selection
	//--------------------------------------------------------------------------
	assign sr1Addr = ctrl.sr1mux ? ir.op.sr1 : ir.op.dr; // STR reads IR[11:9]
	assign drAddr = ctrl.drmux ? ir.op.dr : 3'd7; // R7 for JSR link

	registerFile regFile
	(
		.Clk(Clk),
		.arstN(arstN),
		.we(ctrl.ldReg),
		.wAddr(drAddr),
		.rAddr1(sr1Addr),
		.rAddr2(ir.op.lo.opnd.fld5[2:0]),
		.wData(bus),
		.rData1(srA),
		.rData2(srB)
	);

	always_comb
	begin
		if (ctrl.sr2mux && ir.op.lo.opnd.immFlag)
			opB = `SLC3_WORD'($signed(ir.op.lo.opnd.fld5)); // SEXT imm5
		else
			opB = srB;
		unique case (ctrl.aluk)
			2'b00: aluOut = srA + opB;
			2'b01: aluOut = srA & opB;
			2'b10: aluOut = ~srA;
			default: aluOut = srA; // Pass
		endcase
	end

	// Address adder, also the path for STR source data
	always_comb
	begin
		addrBase = ctrl.addr1mux ? pc : srA;
		unique case (ctrl.addr2mux)
			2'b00: addrOff = `SLC3_WORD'($signed(ir.ctl.f.jsr.off11));
			2'b01: addrOff = `SLC3_WORD'($signed(ir.ctl.f.br.off9));
			2'b10: addrOff = `SLC3_WORD'($signed(ir.op.lo.offset6));
			default: addrOff = '0;
		endcase
		addrSum = addrBase + addrOff;
	end

	// One source on the bus
	always_comb
	begin
		if (ctrl.gatePc)
			bus = pc;
		else if (ctrl.gateMdr)
			bus = mdr;
		else if (ctrl.gateAlu)
			bus = aluOut;
		else if (ctrl.gateMarmux)
			bus = addrSum;
		else
			bus = '0;
	end

	//--------------------------------------------------------------------------
	// Registers
	//--------------------------------------------------------------------------
	always_ff @(posedge Clk or negedge arstN)
	begin
		if (!arstN)
		begin
			pc <= `SLC3_START_PC;
			cc <= 3'b010; // Zero after reset
			ben <= 1'b0;
			led <= '0;
		end
		else
		begin
			if (ctrl.ldPc)
			begin
				unique case (ctrl.pcmux)
					2'b00: pc <= pc + 1'b1;
					2'b01: pc <= bus;
					2'b10: pc <= addrSum; // Branch, JMP, JSR target
					default: pc <= pc;
				endcase
			end
			if (ctrl.ldCc)
				cc <= {bus[`SLC3_WORD-1], bus == '0, !bus[`SLC3_WORD-1] && bus != '0};
			if (ctrl.ldBen)
				ben <= |(ir.ctl.f.br.nzp & cc); // Uses CC of the previous instruction
			if (ctrl.ldLed)
				led <= ir[11:0];
		end
	end

	// Payload registers
	always_ff @(posedge Clk)
	begin
		if (ctrl.ldMar)
			mar <= bus;
		if (ctrl.ldMdr && (!ctrl.memReq || wbRsp.ack))
			mdr <= ctrl.memReq ? wbRsp.dat : bus; // Read data only on ack
		if (ctrl.ldIr)
			ir <= bus;
	end

	//--------------------------------------------------------------------------
	// Wishbone classic master
	//--------------------------------------------------------------------------
	always_comb
	begin
		wbReq.cyc = ctrl.memReq;
		wbReq.stb = ctrl.memReq;
		wbReq.we = ctrl.memReq & ctrl.memWe;
		wbReq.adr = mar; // Stable for the whole wait state
		wbReq.dat = mdr;
	end

endmodule

//--- logic/slc3Pkg.sv
//--------------------------------------------------------------------------
// Shared types of the SLC-3 core
// Instruction views follow the LC-3 field layout and need a 16-bit word
// Wishbone structs carry classic single-cycle handshakes only
//--------------------------------------------------------------------------
`include "slc3_params.svh"

package slc3Pkg;

	// Operate and memory format
	typedef struct packed {
		logic [3:0] opcode;
		logic [$clog2(`SLC3_NREG)-1:0] dr; // Also SR of STR
		logic [$clog2(`SLC3_NREG)-1:0] sr1; // Also BaseR
		union packed {
			struct packed {
				logic immFlag; // IR[5], imm5 when set
				logic [4:0] fld5; // imm5 or {00, sr2}
			} opnd;
			logic [5:0] offset6; // LDR and STR offset
		} lo;
	} opFmtT;

	// Control-flow format
	typedef struct packed {
		logic [3:0] opcode;
		union packed {
			struct packed {
				logic [2:0] nzp; // Branch condition mask
				logic [8:0] off9;
			} br;
			struct packed {
				logic jsrFlag; // IR[11], PC-relative JSR
				logic [10:0] off11;
			} jsr;
		} f;
	} ctlFmtT;

	typedef union packed {
		opFmtT op;
		ctlFmtT ctl;
	} instrU;

	// Control word from sequencer to datapath
	typedef struct packed {
		logic ldMar;
		logic ldMdr;
		logic ldIr;
		logic ldBen;
		logic ldCc;
		logic ldReg;
		logic ldPc;
		logic ldLed;
		logic gatePc;
		logic gateMdr;
		logic gateAlu;
		logic gateMarmux;
		logic [1:0] pcmux; // 00 PC+1, 01 bus, 10 adder
		logic drmux; // 1 IR[11:9], 0 R7
		logic sr1mux; // 1 IR[8:6], 0 IR[11:9]
		logic sr2mux; // 1 SEXT imm5
		logic addr1mux; // 1 PC, 0 SR1
		logic [1:0] addr2mux; // 00 off11, 01 off9, 10 off6, 11 zero
		logic [1:0] aluk; // 00 add, 01 and, 10 not, 11 pass
		logic memReq; // Hold a Wishbone cycle
		logic memWe;
	} ctrlT;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [`SLC3_WORD-1:0] adr;
		logic [`SLC3_WORD-1:0] dat;
	} wbReqT;

	typedef struct packed {
		logic ack;
		logic [`SLC3_WORD-1:0] dat;
	} wbRspT;

	typedef enum logic [4:0] {
		halted, fetchAddr, fetchWait, loadIr, decode,
		execAdd, execAnd, execNot, brTest, brTake, jmp,
		jsrLink, jsrJump, ldrAddr, ldrWait, ldrWrite,
		strAddr, strData, strWait, pauseHold, pauseRelease
	} seqStateE;

endpackage

//--- logic/slc3_params.svh
//--------------------------------------------------------------------------
// Core-wide sizes for the SLC-3 subset core
// The instruction encoding assumes a 16-bit word and 8 registers
// SLC3_START_PC is the first fetch address after run leaves Halted
//--------------------------------------------------------------------------
`ifndef SLC3_PARAMS_SVH
`define SLC3_PARAMS_SVH

// Data and address width
`define SLC3_WORD 16

// Register file depth, also sets the 3-bit register fields
`define SLC3_NREG 8

// PC value held from reset until run
`define SLC3_START_PC 16'h0000

`endif

//--- run.sh
#!/bin/sh
# Build and run the SLC-3 core testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert \
	-f flist.f \
	--top-module slc3Tb \
	-o slc3Sim
./obj_dir/slc3Sim | tee sim.log

if grep -q "^Testbench passed$" sim.log
then
	echo "Simulation result: pass"
else
	echo "Simulation result: fail"
	exit 1
fi
